// File: design/guard_cfg_pkg.sv
/*
 * Sizes and timing constants of the write-transaction guard.
 * Every other file reads these by scoped name.
 */
`default_nettype none

package guard_cfg_pkg;

  // Linked-data slots, also the credit count the requester starts with
  localparam int unsigned MaxWrTxns    = 4;
  localparam int unsigned HtCapacity   = 4;

  localparam int unsigned IdWidth      = 4;
  localparam int unsigned LenWidth     = 8;
  localparam int unsigned CntWidth     = 10;

  // Budget tick period in clock cycles, power of two
  localparam int unsigned PrescalerDiv = 4;
  localparam int unsigned PrescWidth   = $clog2(PrescalerDiv);

  localparam int unsigned LdIdxWidth   = $clog2(MaxWrTxns);
  localparam int unsigned HtIdxWidth   = $clog2(HtCapacity);
  localparam int unsigned CreditWidth  = $clog2(MaxWrTxns + 1);

  // Fixed margin added to every budget
  localparam int unsigned BudgetSlack  = 2;

endpackage

`default_nettype wire

// File: design/guard_txn_pkg.sv
/*
 * Transaction types of the write guard: bus beats, table records,
 * retirement and interrupt records, and the manager operation code.
 */
`default_nettype none

package guard_txn_pkg;

  typedef logic [guard_cfg_pkg::IdWidth-1:0]     id_t;
  typedef logic [guard_cfg_pkg::LenWidth-1:0]    len_t;
  typedef logic [guard_cfg_pkg::CntWidth-1:0]    cnt_t;
  typedef logic [guard_cfg_pkg::LdIdxWidth-1:0]  ld_idx_t;
  typedef logic [guard_cfg_pkg::HtIdxWidth-1:0]  ht_idx_t;
  typedef logic [guard_cfg_pkg::CreditWidth-1:0] credit_cnt_t;

  typedef struct packed {
    id_t  id;
    len_t len;
  } aw_req_t;

  typedef struct packed {
    id_t id;
  } b_rsp_t;

  // One outstanding write, chained per ID through next
  typedef struct packed {
    aw_req_t metadata;
    cnt_t    counter;
    logic    found_match;
    ld_idx_t next;
    logic    free;
  } linked_data_t;

  typedef struct packed {
    id_t     id;
    ld_idx_t head;
    ld_idx_t tail;
    logic    free;
  } head_tail_t;

  typedef struct packed {
    id_t  id;
    cnt_t latency;
  } retire_t;

  typedef struct packed {
    logic irq;
    logic wr_timeout;
    logic unwanted_wr_resp;
    id_t  txn_id;
  } irq_t;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_ENQ,
    OP_RETIRE,
    OP_FLUSH
  } txn_op_e;

endpackage

`default_nettype wire

// File: design/aw_ingress.sv
/*
 * First pipeline stage of the guard. Registers accepted AW beats and
 * observed B beats before lookup and table update.
 */
`timescale 1ns/1ps
`default_nettype none

module aw_ingress (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   aw_valid_i,
  input  guard_txn_pkg::aw_req_t aw_i,
  input  logic                   b_valid_i,
  input  guard_txn_pkg::b_rsp_t  b_i,
  output logic                   aw_valid_o,
  output guard_txn_pkg::aw_req_t aw_o,
  output logic                   b_valid_o,
  output guard_txn_pkg::b_rsp_t  b_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_valid_o <= 1'b0;
      b_valid_o  <= 1'b0;
    end else begin
      aw_valid_o <= aw_valid_i;
      b_valid_o  <= b_valid_i;
    end
  end

  // Beat payloads only load with their valid
  always_ff @(posedge clk_i) begin
    if (aw_valid_i) begin
      aw_o <= aw_i;
    end
    if (b_valid_i) begin
      b_o <= b_i;
    end
  end

endmodule

`default_nettype wire

// File: design/id_lookup.sv
/*
 * Combinational search of the head/tail table for the enqueue, dequeue
 * and response IDs, plus lowest-free slot selection in both tables.
 */
`timescale 1ns/1ps
`default_nettype none

module id_lookup (
  input  guard_txn_pkg::head_tail_t [guard_cfg_pkg::HtCapacity-1:0]  head_tail_i,
  input  guard_txn_pkg::linked_data_t [guard_cfg_pkg::MaxWrTxns-1:0] linked_data_i,
  input  guard_txn_pkg::id_t     in_id_i,
  input  guard_txn_pkg::id_t     out_id_i,
  input  guard_txn_pkg::id_t     rsp_id_i,
  output logic                   no_in_match_o,
  output guard_txn_pkg::ht_idx_t match_in_idx_o,
  output logic                   no_out_match_o,
  output guard_txn_pkg::ht_idx_t match_out_idx_o,
  output logic                   rsp_exists_o,
  output guard_txn_pkg::ht_idx_t rsp_idx_o,
  output guard_txn_pkg::ht_idx_t ht_free_idx_o,
  output guard_txn_pkg::ld_idx_t ld_free_idx_o,
  output logic                   full_o
);

  always_comb begin
    no_in_match_o   = 1'b1;
    match_in_idx_o  = '0;
    no_out_match_o  = 1'b1;
    match_out_idx_o = '0;
    rsp_exists_o    = 1'b0;
    rsp_idx_o       = '0;
    ht_free_idx_o   = '0;
    // Downward scan so the lowest free index is the one left standing
    for (int i = guard_cfg_pkg::HtCapacity - 1; i >= 0; i--) begin
      if (head_tail_i[i].free) begin
        ht_free_idx_o = guard_txn_pkg::ht_idx_t'(i);
      end else begin
        if (head_tail_i[i].id == in_id_i) begin
          no_in_match_o  = 1'b0;
          match_in_idx_o = guard_txn_pkg::ht_idx_t'(i);
        end
        if (head_tail_i[i].id == out_id_i) begin
          no_out_match_o  = 1'b0;
          match_out_idx_o = guard_txn_pkg::ht_idx_t'(i);
        end
        if (head_tail_i[i].id == rsp_id_i) begin
          rsp_exists_o = 1'b1;
          rsp_idx_o    = guard_txn_pkg::ht_idx_t'(i);
        end
      end
    end
  end

  always_comb begin
    full_o        = 1'b1;
    ld_free_idx_o = '0;
    for (int i = guard_cfg_pkg::MaxWrTxns - 1; i >= 0; i--) begin
      if (linked_data_i[i].free) begin
        full_o        = 1'b0;
        ld_free_idx_o = guard_txn_pkg::ld_idx_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

// File: design/txn_manager.sv
/*
 * Next-state logic of the transaction tables. Enqueues new writes,
 * marks and retires answered ones, and flushes everything on a timeout
 * or an unexpected response.
 */
`timescale 1ns/1ps
`default_nettype none

module txn_manager (
  input  logic                   aw_valid_i,
  input  guard_txn_pkg::aw_req_t aw_i,
  input  logic                   b_valid_i,
  input  guard_txn_pkg::b_rsp_t  b_i,
  input  logic                   no_in_match_i,
  input  guard_txn_pkg::ht_idx_t match_in_idx_i,
  input  logic                   no_out_match_i,
  input  guard_txn_pkg::ht_idx_t match_out_idx_i,
  input  logic                   rsp_exists_i,
  input  guard_txn_pkg::ht_idx_t rsp_idx_i,
  input  guard_txn_pkg::ht_idx_t ht_free_idx_i,
  input  guard_txn_pkg::ld_idx_t ld_free_idx_i,
  input  logic                   full_i,
  input  guard_txn_pkg::cnt_t    accum_i,
  input  guard_txn_pkg::head_tail_t [guard_cfg_pkg::HtCapacity-1:0]  head_tail_q_i,
  output guard_txn_pkg::head_tail_t [guard_cfg_pkg::HtCapacity-1:0]  head_tail_d_o,
  input  guard_txn_pkg::linked_data_t [guard_cfg_pkg::MaxWrTxns-1:0] linked_data_q_i,
  output guard_txn_pkg::linked_data_t [guard_cfg_pkg::MaxWrTxns-1:0] linked_data_d_o,
  output guard_txn_pkg::id_t          out_id_o,
  output guard_txn_pkg::cnt_t         accum_add_o,
  output guard_txn_pkg::cnt_t         freed_len_o,
  output guard_txn_pkg::txn_op_e      op_o,
  output guard_txn_pkg::retire_t      retire_o,
  output guard_txn_pkg::credit_cnt_t  freed_o,
  output guard_txn_pkg::irq_t         irq_cause_o
);

  logic                   retire_hit, timeout, unwanted, flush, enq;
  logic                   head_marked, ht_popped, new_entry;
  guard_txn_pkg::ld_idx_t ret_idx, rsp_head, mark_idx, enq_ld;
  guard_txn_pkg::ht_idx_t enq_ht;
  guard_txn_pkg::id_t     to_id;
  guard_txn_pkg::cnt_t    scaled_len;

  // Marked record to retire and expired records, lowest index wins
  always_comb begin
    retire_hit = 1'b0;
    ret_idx    = '0;
    timeout    = 1'b0;
    to_id      = '0;
    for (int i = guard_cfg_pkg::MaxWrTxns - 1; i >= 0; i--) begin
      if (!linked_data_q_i[i].free && linked_data_q_i[i].found_match) begin
        retire_hit = 1'b1;
        ret_idx    = guard_txn_pkg::ld_idx_t'(i);
      end
      if (!linked_data_q_i[i].free && !linked_data_q_i[i].found_match &&
          linked_data_q_i[i].counter == '0) begin
        timeout = 1'b1;
        to_id   = linked_data_q_i[i].metadata.id;
      end
    end
  end

  assign out_id_o   = linked_data_q_i[ret_idx].metadata.id;
  assign scaled_len = guard_txn_pkg::cnt_t'(aw_i.len) >> guard_cfg_pkg::PrescWidth;

  // A head already waiting to retire passes the response on to its successor
  assign rsp_head    = head_tail_q_i[rsp_idx_i].head;
  assign head_marked = linked_data_q_i[rsp_head].found_match;
  assign mark_idx    = head_marked ? linked_data_q_i[rsp_head].next : rsp_head;
  assign unwanted    = b_valid_i && (!rsp_exists_i ||
                       (head_marked && rsp_head == head_tail_q_i[rsp_idx_i].tail));
  assign flush       = timeout || unwanted;
  assign enq         = aw_valid_i && (!full_i || flush);

  always_comb begin
    head_tail_d_o   = head_tail_q_i;
    linked_data_d_o = linked_data_q_i;
    accum_add_o     = '0;
    freed_len_o     = '0;
    op_o            = guard_txn_pkg::OP_NONE;
    retire_o        = '0;
    freed_o         = '0;
    irq_cause_o     = '0;
    ht_popped       = 1'b0;
    new_entry       = 1'b0;
    enq_ld          = ld_free_idx_i;
    enq_ht          = ht_free_idx_i;

    if (flush) begin
      op_o                         = guard_txn_pkg::OP_FLUSH;
      irq_cause_o.irq              = 1'b1;
      irq_cause_o.wr_timeout       = timeout;
      irq_cause_o.unwanted_wr_resp = unwanted;
      irq_cause_o.txn_id           = timeout ? to_id : b_i.id;
      for (int i = 0; i < guard_cfg_pkg::MaxWrTxns; i++) begin
        if (!linked_data_q_i[i].free) begin
          freed_o = freed_o + guard_txn_pkg::credit_cnt_t'(1);
        end
        linked_data_d_o[i]      = '0;
        linked_data_d_o[i].free = 1'b1;
      end
      for (int i = 0; i < guard_cfg_pkg::HtCapacity; i++) begin
        head_tail_d_o[i]      = '0;
        head_tail_d_o[i].free = 1'b1;
      end
    end else begin
      if (retire_hit && !no_out_match_i) begin
        op_o        = guard_txn_pkg::OP_RETIRE;
        retire_o    = '{id: out_id_o, latency: linked_data_q_i[ret_idx].counter};
        freed_o     = guard_txn_pkg::credit_cnt_t'(1);
        freed_len_o = guard_txn_pkg::cnt_t'(linked_data_q_i[ret_idx].metadata.len) >>
                      guard_cfg_pkg::PrescWidth;
        linked_data_d_o[ret_idx]      = '0;
        linked_data_d_o[ret_idx].free = 1'b1;
        if (head_tail_q_i[match_out_idx_i].head == head_tail_q_i[match_out_idx_i].tail) begin
          ht_popped                          = 1'b1;
          head_tail_d_o[match_out_idx_i]      = '0;
          head_tail_d_o[match_out_idx_i].free = 1'b1;
        end else begin
          head_tail_d_o[match_out_idx_i].head = linked_data_q_i[ret_idx].next;
        end
      end
      if (b_valid_i) begin
        linked_data_d_o[mark_idx].found_match = 1'b1;
      end
    end

    if (enq) begin
      if (op_o == guard_txn_pkg::OP_NONE) begin
        op_o = guard_txn_pkg::OP_ENQ;
      end
      accum_add_o = scaled_len;
      // After a flush the new write lands in the first slot of empty tables
      if (flush) begin
        enq_ld    = '0;
        enq_ht    = '0;
        new_entry = 1'b1;
      end else begin
        new_entry = no_in_match_i || (ht_popped && match_out_idx_i == match_in_idx_i);
        enq_ht    = no_in_match_i ? ht_free_idx_i : match_in_idx_i;
      end
      if (new_entry) begin
        head_tail_d_o[enq_ht] = '{id: aw_i.id, head: enq_ld, tail: enq_ld, free: 1'b0};
      end else begin
        linked_data_d_o[head_tail_q_i[enq_ht].tail].next = enq_ld;
        head_tail_d_o[enq_ht].tail                       = enq_ld;
      end
      linked_data_d_o[enq_ld] = '{
        metadata:    aw_i,
        counter:     (flush ? '0 : accum_i) + scaled_len +
                     guard_txn_pkg::cnt_t'(guard_cfg_pkg::BudgetSlack),
        found_match: 1'b0,
        next:        '0,
        free:        1'b0
      };
    end
  end

endmodule

`default_nettype wire

// File: design/txn_table.sv
/*
 * Table registers of the guard. Holds head/tail and linked-data state,
 * counts budgets down on each prescaler tick and tracks the backlog.
 */
`timescale 1ns/1ps
`default_nettype none

module txn_table (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  guard_txn_pkg::head_tail_t [guard_cfg_pkg::HtCapacity-1:0]  head_tail_d_i,
  input  guard_txn_pkg::linked_data_t [guard_cfg_pkg::MaxWrTxns-1:0] linked_data_d_i,
  input  guard_txn_pkg::cnt_t    accum_add_i,
  input  guard_txn_pkg::txn_op_e op_i,
  input  guard_txn_pkg::cnt_t    freed_len_i,
  output guard_txn_pkg::head_tail_t [guard_cfg_pkg::HtCapacity-1:0]  head_tail_q_o,
  output guard_txn_pkg::linked_data_t [guard_cfg_pkg::MaxWrTxns-1:0] linked_data_q_o,
  output guard_txn_pkg::cnt_t    accum_o
);

  logic [guard_cfg_pkg::PrescWidth-1:0]                        presc_q;
  logic                                                        tick;
  guard_txn_pkg::linked_data_t [guard_cfg_pkg::MaxWrTxns-1:0] linked_data_n;

  assign tick = &presc_q;

  // Answered records keep their remaining budget for the retire report
  always_comb begin
    linked_data_n = linked_data_d_i;
    if (tick) begin
      for (int i = 0; i < guard_cfg_pkg::MaxWrTxns; i++) begin
        if (!linked_data_n[i].free && !linked_data_n[i].found_match &&
            linked_data_n[i].counter != '0) begin
          linked_data_n[i].counter = linked_data_n[i].counter - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      presc_q <= '0;
      accum_o <= '0;
      for (int i = 0; i < guard_cfg_pkg::HtCapacity; i++) begin
        head_tail_q_o[i] <= '{free: 1'b1, default: '0};
      end
      for (int i = 0; i < guard_cfg_pkg::MaxWrTxns; i++) begin
        linked_data_q_o[i] <= '{free: 1'b1, default: '0};
      end
    end else begin
      presc_q         <= presc_q + 1'b1;
      head_tail_q_o   <= head_tail_d_i;
      linked_data_q_o <= linked_data_n;
      if (op_i == guard_txn_pkg::OP_FLUSH) begin
        accum_o <= accum_add_i;
      end else begin
        accum_o <= accum_o + accum_add_i - freed_len_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/irq_regs.sv
/*
 * Output registers: retire report, returned credits and the sticky
 * interrupt record, which a pulse on irq_clear_i clears.
 */
`timescale 1ns/1ps
`default_nettype none

module irq_regs (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  guard_txn_pkg::txn_op_e     op_i,
  input  guard_txn_pkg::retire_t     retire_i,
  input  guard_txn_pkg::credit_cnt_t freed_i,
  input  guard_txn_pkg::irq_t        irq_cause_i,
  input  logic                       irq_clear_i,
  output logic                       retire_valid_o,
  output guard_txn_pkg::retire_t     retire_o,
  output guard_txn_pkg::credit_cnt_t aw_credit_o,
  output guard_txn_pkg::irq_t        irq_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      retire_valid_o <= 1'b0;
      aw_credit_o    <= '0;
      irq_o          <= '0;
    end else begin
      retire_valid_o <= (op_i == guard_txn_pkg::OP_RETIRE);
      aw_credit_o    <= freed_i;
      // First cause is kept, a new one in the clear cycle is not lost
      if (irq_cause_i.irq && (!irq_o.irq || irq_clear_i)) begin
        irq_o <= irq_cause_i;
      end else if (irq_clear_i) begin
        irq_o <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    retire_o <= retire_i;
  end

endmodule

`default_nettype wire

// File: design/wr_guard_top.sv
/*
 * Top of the write-transaction guard. Observes AW and B, times every
 * outstanding write and returns AW credits to the requester.
 */
`timescale 1ns/1ps
`default_nettype none

module wr_guard_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       aw_valid_i,
  input  guard_txn_pkg::aw_req_t     aw_i,
  input  logic                       b_valid_i,
  input  guard_txn_pkg::b_rsp_t      b_i,
  input  logic                       irq_clear_i,
  output guard_txn_pkg::credit_cnt_t aw_credit_o,
  output logic                       retire_valid_o,
  output guard_txn_pkg::retire_t     retire_o,
  output guard_txn_pkg::irq_t        irq_o
);

  logic                        aw_valid_q, b_valid_q;
  guard_txn_pkg::aw_req_t      aw_q;
  guard_txn_pkg::b_rsp_t       b_q;
  logic                        no_in_match, no_out_match, rsp_exists, full;
  guard_txn_pkg::ht_idx_t      match_in_idx, match_out_idx, rsp_idx, ht_free_idx;
  guard_txn_pkg::ld_idx_t      ld_free_idx;
  guard_txn_pkg::id_t          out_id;
  guard_txn_pkg::cnt_t         accum, accum_add, freed_len;
  guard_txn_pkg::txn_op_e      op;
  guard_txn_pkg::retire_t      retire;
  guard_txn_pkg::credit_cnt_t  freed;
  guard_txn_pkg::irq_t         irq_cause;

  guard_txn_pkg::head_tail_t [guard_cfg_pkg::HtCapacity-1:0]  head_tail_q, head_tail_d;
  guard_txn_pkg::linked_data_t [guard_cfg_pkg::MaxWrTxns-1:0] linked_data_q, linked_data_d;

  aw_ingress i_aw_ingress (
    .clk_i, .arst_n_i, .aw_valid_i, .aw_i, .b_valid_i, .b_i,
    .aw_valid_o (aw_valid_q),
    .aw_o       (aw_q),
    .b_valid_o  (b_valid_q),
    .b_o        (b_q)
  );

  id_lookup i_id_lookup (
    .head_tail_i     (head_tail_q),
    .linked_data_i   (linked_data_q),
    .in_id_i         (aw_q.id),
    .out_id_i        (out_id),
    .rsp_id_i        (b_q.id),
    .no_in_match_o   (no_in_match),
    .match_in_idx_o  (match_in_idx),
    .no_out_match_o  (no_out_match),
    .match_out_idx_o (match_out_idx),
    .rsp_exists_o    (rsp_exists),
    .rsp_idx_o       (rsp_idx),
    .ht_free_idx_o   (ht_free_idx),
    .ld_free_idx_o   (ld_free_idx),
    .full_o          (full)
  );

  txn_manager i_txn_manager (
    .aw_valid_i      (aw_valid_q),
    .aw_i            (aw_q),
    .b_valid_i       (b_valid_q),
    .b_i             (b_q),
    .no_in_match_i   (no_in_match),
    .match_in_idx_i  (match_in_idx),
    .no_out_match_i  (no_out_match),
    .match_out_idx_i (match_out_idx),
    .rsp_exists_i    (rsp_exists),
    .rsp_idx_i       (rsp_idx),
    .ht_free_idx_i   (ht_free_idx),
    .ld_free_idx_i   (ld_free_idx),
    .full_i          (full),
    .accum_i         (accum),
    .head_tail_q_i   (head_tail_q),
    .head_tail_d_o   (head_tail_d),
    .linked_data_q_i (linked_data_q),
    .linked_data_d_o (linked_data_d),
    .out_id_o        (out_id),
    .accum_add_o     (accum_add),
    .freed_len_o     (freed_len),
    .op_o            (op),
    .retire_o        (retire),
    .freed_o         (freed),
    .irq_cause_o     (irq_cause)
  );

  txn_table i_txn_table (
    .clk_i, .arst_n_i,
    .head_tail_d_i   (head_tail_d),
    .linked_data_d_i (linked_data_d),
    .accum_add_i     (accum_add),
    .op_i            (op),
    .freed_len_i     (freed_len),
    .head_tail_q_o   (head_tail_q),
    .linked_data_q_o (linked_data_q),
    .accum_o         (accum)
  );

  irq_regs i_irq_regs (
    .clk_i, .arst_n_i,
    .op_i        (op),
    .retire_i    (retire),
    .freed_i     (freed),
    .irq_cause_i (irq_cause),
    .irq_clear_i,
    .retire_valid_o,
    .retire_o,
    .aw_credit_o,
    .irq_o
  );

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
/*
 * Testbench clock and reset source. 40 ns clock, reset held low for
 * the first two rising edges.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #20 clk_o = ~clk_o;
    end
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: testbench/tb_wr_guard.sv
/*
 * Testbench of the write guard. Drives AW and B beats, models budgets,
 * per-ID order and credits, and checks retire, credit and irq outputs.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_wr_guard;

  localparam int     RandSteps   = 80;
  localparam int     IssuedBeats = 2 * RandSteps + 24;
  localparam int     WorstBudget = (guard_cfg_pkg::MaxWrTxns * 255 / guard_cfg_pkg::PrescalerDiv
                                    + guard_cfg_pkg::BudgetSlack) * guard_cfg_pkg::PrescalerDiv;
  localparam longint WatchdogNs  = longint'(IssuedBeats) * WorstBudget * 40;

  logic                       clk;
  logic                       arst_n;
  logic                       aw_valid_i;
  guard_txn_pkg::aw_req_t     aw_i;
  logic                       b_valid_i;
  guard_txn_pkg::b_rsp_t      b_i;
  logic                       irq_clear_i;
  guard_txn_pkg::credit_cnt_t aw_credit_o;
  logic                       retire_valid_o;
  guard_txn_pkg::retire_t     retire_o;
  guard_txn_pkg::irq_t        irq_o;

  // Writes without a response and responses not yet retired
  guard_txn_pkg::retire_t pend_q[$];
  int                     pend_len_q[$];
  guard_txn_pkg::retire_t exp_retire_q[$];
  int                     exp_len_q[$];
  int                     backlog   = 0;
  int                     credits   = guard_cfg_pkg::MaxWrTxns;
  int                     flush_seen = 0;
  logic                   flush_exp = 1'b0;
  guard_txn_pkg::irq_t    irq_exp   = '0;
  guard_txn_pkg::irq_t    irq_now   = '0;
  int unsigned            rng_state = 53;

  tb_clk_gen i_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  wr_guard_top i_dut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .aw_valid_i     (aw_valid_i),
    .aw_i           (aw_i),
    .b_valid_i      (b_valid_i),
    .b_i            (b_i),
    .irq_clear_i    (irq_clear_i),
    .aw_credit_o    (aw_credit_o),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .irq_o          (irq_o)
  );

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1);
  endtask

  function automatic int unsigned next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state >> 16;
  endfunction

  // Budget is the backlog plus the length over the prescaler plus two
  function automatic guard_txn_pkg::cnt_t ref_budget(int backlog_now,
                                                     guard_txn_pkg::len_t len);
    return guard_txn_pkg::cnt_t'(backlog_now + int'(len) / 4 + 2);
  endfunction

  task automatic check_retire(guard_txn_pkg::retire_t got, guard_txn_pkg::retire_t exp);
    if (got.id !== exp.id || got.latency > exp.latency) begin
      $display("ERROR retire_o: got id=%h latency=%h, expected id=%h latency<=%h",
               got.id, got.latency, exp.id, exp.latency);
      abort_run();
    end
  endtask

  task automatic check_irq(guard_txn_pkg::irq_t got, guard_txn_pkg::irq_t exp);
    if (got !== exp) begin
      $display("ERROR irq_o: got %h, expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_credit(guard_txn_pkg::credit_cnt_t got,
                              guard_txn_pkg::credit_cnt_t exp);
    if (got !== exp) begin
      $display("ERROR aw_credit_o: got %h, expected %h", got, exp);
      abort_run();
    end
  endtask

  function automatic void record_aw(guard_txn_pkg::aw_req_t aw);
    guard_txn_pkg::retire_t rec;
    rec.id      = aw.id;
    rec.latency = ref_budget(backlog, aw.len);
    pend_q.push_back(rec);
    pend_len_q.push_back(int'(aw.len) / 4);
    backlog = backlog + int'(aw.len) / 4;
    credits = credits - 1;
  endfunction

  // The oldest unanswered write of the ID is the one the response retires
  task automatic record_b(guard_txn_pkg::id_t id);
    int idx;
    idx = -1;
    for (int i = pend_q.size() - 1; i >= 0; i--) begin
      if (pend_q[i].id == id) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      $display("Response for ID %h has no outstanding write in the model", id);
      abort_run();
    end
    exp_retire_q.push_back(pend_q[idx]);
    exp_len_q.push_back(pend_len_q[idx]);
    pend_q.delete(idx);
    pend_len_q.delete(idx);
  endtask

  task automatic step(logic aw_v, guard_txn_pkg::aw_req_t aw, logic b_v,
                      guard_txn_pkg::b_rsp_t b);
    aw_valid_i = aw_v;
    aw_i       = aw;
    b_valid_i  = b_v;
    b_i        = b;
    @(posedge clk);
    #1;
    aw_valid_i = 1'b0;
    b_valid_i  = 1'b0;
  endtask

  task automatic idle(int cycles);
    repeat (cycles) step(1'b0, '0, 1'b0, '0);
  endtask

  task automatic issue_aw(int id, int len);
    guard_txn_pkg::aw_req_t aw;
    int                     waited;
    waited = 0;
    while (credits == 0) begin
      if (waited > 100) begin
        $display("No AW credit came back while writes were waiting to be sent");
        abort_run();
      end
      idle(1);
      waited++;
    end
    aw.id  = guard_txn_pkg::id_t'(id);
    aw.len = guard_txn_pkg::len_t'(len);
    record_aw(aw);
    step(1'b1, aw, 1'b0, '0);
  endtask

  task automatic issue_b(int id);
    guard_txn_pkg::b_rsp_t b;
    b.id = guard_txn_pkg::id_t'(id);
    record_b(b.id);
    step(1'b0, '0, 1'b1, b);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_retire_q.size() != 0 || credits != guard_cfg_pkg::MaxWrTxns) begin
      if (waited > 40) begin
        $display("Answered writes did not retire or their credits did not return");
        abort_run();
      end
      idle(1);
      waited++;
    end
  endtask

  // Returns the number of cycles until the expected flush shows up
  task automatic wait_flush(int limit, output int cycles);
    int start;
    start  = flush_seen;
    cycles = 0;
    while (flush_seen == start) begin
      if (cycles > limit) begin
        $display("Expected interrupt and credit flush did not happen");
        abort_run();
      end
      idle(1);
      cycles++;
    end
  endtask

  task automatic clear_irq();
    irq_clear_i = 1'b1;
    @(posedge clk);
    #1;
    irq_clear_i = 1'b0;
    irq_now     = '0;
  endtask

  // Output monitor sampled mid-cycle where outputs are stable
  always @(negedge clk) begin
    if (arst_n) begin
      if (retire_valid_o) begin
        if (exp_retire_q.size() == 0) begin
          $display("Retirement reported with no response outstanding");
          abort_run();
        end
        check_retire(retire_o, exp_retire_q.pop_front());
        backlog = backlog - exp_len_q.pop_front();
        check_credit(aw_credit_o, 1);
      end else if (aw_credit_o != '0) begin
        if (!flush_exp) begin
          $display("Credits returned without a retirement or a flush");
          abort_run();
        end
        check_credit(aw_credit_o,
                     guard_txn_pkg::credit_cnt_t'(guard_cfg_pkg::MaxWrTxns - credits));
        irq_now   = irq_exp;
        flush_exp = 1'b0;
        flush_seen++;
        pend_q.delete();
        pend_len_q.delete();
        exp_retire_q.delete();
        exp_len_q.delete();
        backlog = 0;
      end
      credits = credits + int'(aw_credit_o);
      check_irq(irq_o, irq_now);
    end
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before the tests completed");
    abort_run();
  end

  initial begin
    logic                   do_aw;
    logic                   do_b;
    guard_txn_pkg::aw_req_t aw;
    guard_txn_pkg::b_rsp_t  b;
    int                     pick;
    int                     budget_a;
    int                     cycles;

    aw_valid_i  = 1'b0;
    aw_i        = '0;
    b_valid_i   = 1'b0;
    b_i         = '0;
    irq_clear_i = 1'b0;
    @(posedge arst_n);
    @(posedge clk);
    #1;

    // Full credit window and in-order retirement per ID
    issue_aw(5, 200);
    issue_aw(5, 100);
    issue_aw(6, 160);
    issue_aw(5, 60);
    idle(10);
    issue_b(5);
    issue_b(5);
    issue_b(6);
    issue_b(5);
    drain();

    // Random interleaved traffic where long bursts keep budgets far from zero
    for (int s = 0; s < RandSteps; s++) begin
      do_aw = (credits > 0) && (next_rand() % 2 == 0);
      do_b  = (pend_q.size() > 0) && (next_rand() % 3 != 0);
      aw.id  = guard_txn_pkg::id_t'(next_rand() % 8);
      aw.len = guard_txn_pkg::len_t'(128 + next_rand() % 128);
      b      = '0;
      if (do_b) begin
        pick = (next_rand() % 3 == 0) ? 0 : int'(next_rand() % pend_q.size());
        b.id = pend_q[pick].id;
        record_b(b.id);
      end
      if (do_aw) begin
        record_aw(aw);
      end
      step(do_aw, aw, do_b, b);
    end
    while (pend_q.size() != 0) begin
      issue_b(int'(pend_q[0].id));
    end
    drain();

    // Response to an ID with nothing outstanding
    issue_aw(1, 200);
    issue_aw(3, 200);
    idle(2);
    irq_exp   = '{irq: 1'b1, wr_timeout: 1'b0, unwanted_wr_resp: 1'b1,
                  txn_id: guard_txn_pkg::id_t'(9)};
    flush_exp = 1'b1;
    b.id      = guard_txn_pkg::id_t'(9);
    step(1'b0, '0, 1'b1, b);
    wait_flush(20, cycles);
    clear_irq();
    idle(2);

    // Writes left unanswered until the oldest one times out
    budget_a  = int'(ref_budget(backlog, 8));
    irq_exp   = '{irq: 1'b1, wr_timeout: 1'b1, unwanted_wr_resp: 1'b0,
                  txn_id: guard_txn_pkg::id_t'(2)};
    flush_exp = 1'b1;
    issue_aw(2, 8);
    issue_aw(11, 40);
    wait_flush(4 * (budget_a + 2), cycles);
    if (cycles < 4 * (budget_a - 1) || cycles > 4 * (budget_a + 1)) begin
      $display("Timeout came after %0d cycles, outside %0d to %0d", cycles,
               4 * (budget_a - 1), 4 * (budget_a + 1));
      abort_run();
    end

    // Traffic after the record is cleared
    clear_irq();
    issue_aw(4, 150);
    issue_aw(4, 150);
    idle(3);
    issue_b(4);
    issue_b(4);
    drain();
    idle(4);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
design/guard_cfg_pkg.sv
design/guard_txn_pkg.sv
design/aw_ingress.sv
design/id_lookup.sv
design/txn_manager.sv
design/txn_table.sv
design/irq_regs.sv
design/wr_guard_top.sv
testbench/tb_clk_gen.sv
testbench/tb_wr_guard.sv

// File: run.sh
#!/bin/sh
# Build the write guard testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_wr_guard -o sim_wr_guard
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_wr_guard
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
